// File: Bender.yml
package:
  name: wt_cache

sources:
  - source/cache_pkg.sv
  - source/cache_memory.sv
  - source/write_through_buffer.sv
  - source/cache_back_end.sv
  - source/cache_top.sv
  - target: simulation
    files:
      - dv/cache_checker.sv
      - dv/cache_tb.sv

// File: dv/cache_checker.sv
`default_nettype none

module cache_checker #(
   parameter int ADDR_W = cache_pkg::def_addr_w,
   parameter int DATA_W = cache_pkg::def_data_w
) (
   input  logic                clk,
   input  logic                rst_n,
   // front end
   input  logic [ADDR_W-1:0]   addr,
   input  logic [DATA_W-1:0]   wdata,
   input  logic [DATA_W/8-1:0] wstrb,
   input  logic [DATA_W-1:0]   rdata,
   input  logic                ack,
   input  logic                wtb_empty,
   // memory port
   input  logic                mem_req,
   input  logic                mem_we,
   input  logic [ADDR_W-1:0]   mem_addr,
   input  logic [DATA_W-1:0]   mem_wdata,
   input  logic [DATA_W/8-1:0] mem_wstrb,
   input  logic                mem_ack
);

   localparam int nbytes = DATA_W / 8;

   // expected memory contents
   logic [DATA_W-1:0] ref_mem [2**ADDR_W];
   // memory as written out by the DUT
   logic [DATA_W-1:0] mem_image [2**ADDR_W];

   string test_name = "";
   int    exp_reads = 0;
   int    test_reads = 0;
   int    test_errors = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   int    total_reads = 0;
   int    total_writes = 0;

   function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [nbytes-1:0] strb);
      logic [DATA_W-1:0] res;
      res = old_word;
      for (int b = 0; b < nbytes; b++) begin
         if (strb[b])
            res[8*b +: 8] = new_word[8*b +: 8];
      end
      return res;
   endfunction

   task automatic report_value(input string exp_s, input string act_s, input string what);
      $display("Fail %s expected %s actual %s (%s)", test_name, exp_s, act_s, what);
      test_errors++;
   endtask

   task automatic note_failure(input string msg);
      $display("%s: %s", test_name, msg);
      test_errors++;
   endtask

   task automatic set_ref(input int a, input logic [DATA_W-1:0] v);
      ref_mem[a] = v;
      mem_image[a] = v;
   endtask

   task automatic start_test(input string name, input int reads);
      test_name = name;
      exp_reads = reads;
      test_reads = 0;
      test_errors = 0;
   endtask

   task automatic check_idle();
      if (wtb_empty !== 1'b1)
         report_value("1", $sformatf("%b", wtb_empty), "wtb_empty");
      if (ack !== 1'b0)
         report_value("0", $sformatf("%b", ack), "ack");
   endtask

   task automatic compare_memory();
      int bad;
      bad = 0;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         if (mem_image[a] !== ref_mem[a]) begin
            bad++;
            if (bad <= 4)
               report_value($sformatf("%h", ref_mem[a]), $sformatf("%h", mem_image[a]),
                            $sformatf("memory word %h", a));
         end
      end
      if (bad > 4)
         note_failure($sformatf("%0d more memory words differ", bad - 4));
   endtask

   task automatic finish_test();
      if (test_reads != exp_reads)
         report_value($sformatf("%0d", exp_reads), $sformatf("%0d", test_reads),
                      "memory reads");
      tests_run++;
      if (test_errors == 0) begin
         $display("test %s passed, %0d memory reads", test_name, test_reads);
      end else begin
         tests_failed++;
         $display("test %s failed with %0d errors", test_name, test_errors);
      end
   endtask

   task automatic print_summary();
      $display("tests %0d, failed %0d, memory reads %0d, memory writes %0d",
               tests_run, tests_failed, total_reads, total_writes);
   endtask

   // inputs move on the falling edge so these are pre-edge values
   always @(posedge clk) begin
      if (rst_n) begin
         if (mem_req && mem_ack) begin
            if (mem_we) begin
               total_writes++;
               mem_image[mem_addr] = merge_bytes(mem_image[mem_addr], mem_wdata, mem_wstrb);
            end else begin
               total_reads++;
               test_reads++;
            end
         end
         if (ack) begin
            if (wstrb == '0) begin
               if (rdata !== ref_mem[addr])
                  report_value($sformatf("%h", ref_mem[addr]), $sformatf("%h", rdata),
                               $sformatf("rdata at %h", addr));
            end else begin
               ref_mem[addr] = merge_bytes(ref_mem[addr], wdata, wstrb);
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: dv/cache_tb.sv
`default_nettype none

module cache_tb;

   import cache_pkg::*;

   localparam int addr_w = def_addr_w;
   localparam int data_w = def_data_w;
   localparam int nbytes = data_w / 8;
   localparam int line_words = 2**def_word_offset_w;
   localparam int ack_timeout = 400;
   localparam int drain_timeout = 400;

   typedef enum logic [1:0] {
      OP_READ  = 2'd0,
      OP_WRITE = 2'd1,
      OP_INVAL = 2'd2,
      OP_FLUSH = 2'd3
   } op_e;

   typedef struct packed {
      op_e               op;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;
      logic [nbytes-1:0] wstrb;
      int                exp_reads;
      logic              slow;
   } step_t;

   logic              clk;
   logic              rst_n;
   logic              req;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] wdata;
   logic [nbytes-1:0] wstrb;
   logic [data_w-1:0] rdata;
   logic              ack;
   logic              invalidate;
   logic              wtb_empty;
   logic              mem_req;
   logic              mem_we;
   logic [addr_w-1:0] mem_addr;
   logic [data_w-1:0] mem_wdata;
   logic [nbytes-1:0] mem_wstrb;
   logic [data_w-1:0] mem_rdata = '0;
   logic              mem_ack = 1'b0;

   // memory model state
   logic [data_w-1:0] mem_model [2**addr_w];
   logic [31:0]       rng;
   logic              slow_mem = 1'b0;
   logic              mem_busy = 1'b0;
   int                lat_left = 0;

   step_t steps[$];
   string step_names[$];

   cache_top #(
      .ADDR_W        (addr_w),
      .DATA_W        (data_w),
      .NLINES_W      (def_nlines_w),
      .WORD_OFFSET_W (def_word_offset_w),
      .WTBUF_DEPTH_W (def_wtbuf_depth_w)
   ) dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .req        (req),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .rdata      (rdata),
      .ack        (ack),
      .invalidate (invalidate),
      .wtb_empty  (wtb_empty),
      .mem_req    (mem_req),
      .mem_we     (mem_we),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wstrb  (mem_wstrb),
      .mem_rdata  (mem_rdata),
      .mem_ack    (mem_ack)
   );

   cache_checker #(
      .ADDR_W (addr_w),
      .DATA_W (data_w)
   ) chk (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (rdata),
      .ack       (ack),
      .wtb_empty (wtb_empty),
      .mem_req   (mem_req),
      .mem_we    (mem_we),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_ack   (mem_ack)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic add_step(input string name, input op_e op, input logic [addr_w-1:0] a,
                           input logic [data_w-1:0] d, input logic [nbytes-1:0] s,
                           input int reads, input logic slow);
      step_t st;
      st.op = op;
      st.addr = a;
      st.wdata = d;
      st.wstrb = s;
      st.exp_reads = reads;
      st.slow = slow;
      steps.push_back(st);
      step_names.push_back(name);
   endtask

   task automatic run_access(input step_t st, output bit ok);
      @(negedge clk);
      req = 1'b1;
      addr = st.addr;
      wdata = st.wdata;
      wstrb = st.wstrb;
      ok = 1'b0;
      for (int n = 0; n < ack_timeout && !ok; n++) begin
         @(negedge clk);
         ok = ack;
      end
      req = 1'b0;
      if (!ok)
         chk.note_failure("the cache gave no ack within the timeout");
   endtask

   task automatic wait_drained(output bit ok);
      ok = 1'b0;
      for (int n = 0; n < drain_timeout && !ok; n++) begin
         @(negedge clk);
         ok = wtb_empty;
      end
      if (!ok)
         chk.note_failure("the write buffer did not empty within the timeout");
   endtask

   task automatic pulse_invalidate();
      @(negedge clk);
      invalidate = 1'b1;
      @(negedge clk);
      invalidate = 1'b0;
   endtask

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // memory model with 1 to 4 cycles of latency plus 8 when slow
   always @(negedge clk) begin
      if (!rst_n) begin
         mem_ack <= 1'b0;
         mem_busy = 1'b0;
      end else if (mem_ack) begin
         mem_ack <= 1'b0;
      end else if (mem_req) begin
         if (!mem_busy) begin
            mem_busy = 1'b1;
            rng = xorshift(rng);
            lat_left = 1 + int'(rng % 4) + (slow_mem ? 8 : 0);
         end
         lat_left = lat_left - 1;
         if (lat_left == 0) begin
            mem_busy = 1'b0;
            mem_ack <= 1'b1;
            if (mem_we) begin
               for (int b = 0; b < nbytes; b++) begin
                  if (mem_wstrb[b])
                     mem_model[mem_addr][8*b +: 8] = mem_wdata[8*b +: 8];
               end
            end else begin
               mem_rdata <= mem_model[mem_addr];
            end
         end
      end
   end

   initial begin
      logic [data_w-1:0] v;
      step_t st;
      bit ok;
      req = 1'b0;
      addr = '0;
      wdata = '0;
      wstrb = '0;
      invalidate = 1'b0;
      rst_n = 1'b0;
      rng = 32'h3e87;
      for (int a = 0; a < 2**addr_w; a++) begin
         rng = xorshift(rng);
         v = rng ^ 32'(a);
         mem_model[a] = v;
         chk.set_ref(a, v);
      end

      // name, op, addr, wdata, wstrb, memory reads, slow memory
      add_step("cold_read", OP_READ, 12'h040, '0, '0, line_words, 1'b0);
      add_step("same_line_read", OP_READ, 12'h043, '0, '0, 0, 1'b0);
      add_step("partial_write", OP_WRITE, 12'h041, 32'ha5a5_5a5a, 4'b0101, 0, 1'b0);
      add_step("merged_read", OP_READ, 12'h041, '0, '0, 0, 1'b0);
      add_step("merged_in_memory", OP_FLUSH, '0, '0, '0, 0, 1'b0);
      add_step("write_before_miss", OP_WRITE, 12'h300, 32'h3c3c_c3c3, 4'b1111, 0, 1'b1);
      add_step("write_miss", OP_WRITE, 12'h2a6, 32'h1234_5678, 4'b1111, 0, 1'b1);
      add_step("read_after_write_miss", OP_READ, 12'h2a6, '0, '0, line_words, 1'b0);
      add_step("burst_0", OP_WRITE, 12'h2a4, 32'h0bad_f00d, 4'b1111, 0, 1'b1);
      add_step("burst_1", OP_WRITE, 12'h2a5, 32'h7777_0001, 4'b0011, 0, 1'b1);
      add_step("burst_2", OP_WRITE, 12'h040, 32'hc0de_cafe, 4'b1111, 0, 1'b1);
      add_step("burst_3", OP_WRITE, 12'h7fc, 32'h5555_aaaa, 4'b1000, 0, 1'b1);
      add_step("burst_4", OP_WRITE, 12'h2a6, 32'h9999_1111, 4'b1100, 0, 1'b1);
      add_step("burst_5", OP_WRITE, 12'h100, 32'h0123_4567, 4'b1111, 0, 1'b1);
      add_step("burst_drained", OP_FLUSH, '0, '0, '0, 0, 1'b1);
      add_step("invalidate", OP_INVAL, '0, '0, '0, 0, 1'b0);
      add_step("reread_after_invalidate", OP_READ, 12'h040, '0, '0, line_words, 1'b0);
      add_step("second_line_reread", OP_READ, 12'h2a5, '0, '0, line_words, 1'b0);

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      @(negedge clk);
      chk.start_test("after_reset", 0);
      chk.check_idle();
      chk.finish_test();

      ok = 1'b1;
      for (int i = 0; i < steps.size() && ok; i++) begin
         st = steps[i];
         chk.start_test(step_names[i], st.exp_reads);
         slow_mem = st.slow;
         case (st.op)
            OP_READ, OP_WRITE: run_access(st, ok);
            OP_INVAL: pulse_invalidate();
            default: begin
               wait_drained(ok);
               if (ok)
                  chk.compare_memory();
            end
         endcase
         chk.finish_test();
      end

      chk.print_summary();
      if (chk.tests_failed == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/cache_back_end.sv
`default_nettype none

module cache_back_end #(
   parameter int ADDR_W        = cache_pkg::def_addr_w,
   parameter int DATA_W        = cache_pkg::def_data_w,
   parameter int WORD_OFFSET_W = cache_pkg::def_word_offset_w
) (
   input  logic                            clk,
   input  logic                            rst_n,
   // write buffer head
   input  logic                            wtb_valid,
   input  logic [ADDR_W-1:0]               wtb_addr,
   input  logic [DATA_W-1:0]               wtb_data,
   input  logic [DATA_W/8-1:0]             wtb_strb,
   output logic                            wtb_pop,
   // line refill
   input  logic                            refill_req,
   input  logic [ADDR_W-WORD_OFFSET_W-1:0] refill_addr,
   output logic                            refill_valid,
   output logic [DATA_W-1:0]               refill_data,
   output logic                            refill_done,
   // external memory port
   output logic                            mem_req,
   output logic                            mem_we,
   output logic [ADDR_W-1:0]               mem_addr,
   output logic [DATA_W-1:0]               mem_wdata,
   output logic [DATA_W/8-1:0]             mem_wstrb,
   input  logic [DATA_W-1:0]               mem_rdata,
   input  logic                            mem_ack
);

   import cache_pkg::*;

   be_state_e                state;
   logic                     req_q;
   logic [WORD_OFFSET_W-1:0] word_cnt;
   logic                     last_word;

   assign last_word = &word_cnt;

   assign mem_req = req_q;
   assign mem_we = (state == DRAIN);
   assign mem_addr = (state == DRAIN) ? wtb_addr : {refill_addr, word_cnt};
   assign mem_wdata = wtb_data;
   assign mem_wstrb = (state == DRAIN) ? wtb_strb : '0;

   assign wtb_pop = (state == DRAIN) && mem_ack;
   assign refill_valid = (state == REFILL) && mem_ack;
   assign refill_data = mem_rdata;
   assign refill_done = refill_valid && last_word;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         req_q <= 1'b0;
         word_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               // pending writes go first so the refill sees them
               if (wtb_valid) begin
                  state <= DRAIN;
                  req_q <= 1'b1;
               end else if (refill_req) begin
                  state <= REFILL;
                  req_q <= 1'b1;
                  word_cnt <= '0;
               end
            end
            DRAIN: begin
               if (mem_ack) begin
                  req_q <= 1'b0;
                  state <= IDLE;
               end
            end
            REFILL: begin
               if (mem_ack) begin
                  req_q <= 1'b0;
                  word_cnt <= word_cnt + 1'b1;
                  if (last_word)
                     state <= IDLE;
               end else if (!req_q) begin
                  // next word of the line
                  req_q <= 1'b1;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req && !mem_ack |=> mem_req && $stable(mem_addr) && $stable(mem_we));

endmodule

`default_nettype wire

// File: source/cache_memory.sv
`default_nettype none

module cache_memory #(
   parameter int ADDR_W        = cache_pkg::def_addr_w,
   parameter int DATA_W        = cache_pkg::def_data_w,
   parameter int NLINES_W      = cache_pkg::def_nlines_w,
   parameter int WORD_OFFSET_W = cache_pkg::def_word_offset_w,
   parameter int WTBUF_DEPTH_W = cache_pkg::def_wtbuf_depth_w
) (
   input  logic                            clk,
   input  logic                            rst_n,
   // front end
   input  logic                            req,
   input  logic [ADDR_W-1:0]               addr,
   input  logic [DATA_W-1:0]               wdata,
   input  logic [DATA_W/8-1:0]             wstrb,
   output logic [DATA_W-1:0]               rdata,
   output logic                            ack,
   input  logic                            invalidate,
   // credit channel to the write buffer
   output logic                            wtb_push,
   output logic [ADDR_W-1:0]               wtb_push_addr,
   output logic [DATA_W-1:0]               wtb_push_data,
   output logic [DATA_W/8-1:0]             wtb_push_strb,
   input  logic                            credit_return,
   // line refill from the back end
   output logic                            refill_req,
   output logic [ADDR_W-WORD_OFFSET_W-1:0] refill_addr,
   input  logic                            refill_valid,
   input  logic [DATA_W-1:0]               refill_data,
   input  logic                            refill_done
);

   localparam int nbytes = DATA_W / 8;
   localparam int tag_w = ADDR_W - NLINES_W - WORD_OFFSET_W;
   localparam int line_word_w = NLINES_W + WORD_OFFSET_W;
   localparam logic [WTBUF_DEPTH_W:0] max_credits = {1'b1, {WTBUF_DEPTH_W{1'b0}}};

   typedef enum logic [1:0] {
      ST_IDLE   = 2'd0,
      ST_LOOKUP = 2'd1,
      ST_REFILL = 2'd2,
      ST_ACK    = 2'd3
   } fe_state_e;

   fe_state_e state;

   // storage arrays
   logic [DATA_W-1:0]   data_mem [2**line_word_w];
   logic [tag_w-1:0]    tag_mem [2**NLINES_W];
   logic [2**NLINES_W-1:0] valid_q;

   logic [tag_w-1:0]         tag;
   logic [NLINES_W-1:0]      index;
   logic [WORD_OFFSET_W-1:0] offset;
   logic [line_word_w-1:0]   word_idx;
   logic                     is_write;
   logic                     hit;
   logic [WTBUF_DEPTH_W:0]   credits;
   logic [WORD_OFFSET_W-1:0] fill_cnt;
   logic [DATA_W-1:0]        rdata_q;

   assign tag = addr[ADDR_W-1 -: tag_w];
   assign index = addr[WORD_OFFSET_W +: NLINES_W];
   assign offset = addr[WORD_OFFSET_W-1:0];
   assign word_idx = addr[line_word_w-1:0];
   assign is_write = |wstrb;
   assign hit = valid_q[index] && (tag_mem[index] == tag);

   assign ack = (state == ST_ACK);
   assign rdata = rdata_q;

   // every write leaves through the buffer in its ack cycle
   assign wtb_push = (state == ST_ACK) && is_write;
   assign wtb_push_addr = addr;
   assign wtb_push_data = wdata;
   assign wtb_push_strb = wstrb;

   assign refill_req = (state == ST_REFILL);
   assign refill_addr = addr[ADDR_W-1:WORD_OFFSET_W];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (req)
                  state <= ST_LOOKUP;
            end
            ST_LOOKUP: begin
               // writes wait here for a credit, no allocation on a miss
               if (is_write) begin
                  if (credits != '0)
                     state <= ST_ACK;
               end else if (hit) begin
                  state <= ST_ACK;
               end else begin
                  state <= ST_REFILL;
               end
            end
            ST_REFILL: begin
               if (refill_done)
                  state <= ST_ACK;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // credits owned by the cache side
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         credits <= max_credits;
      end else begin
         case ({wtb_push, credit_return})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         fill_cnt <= '0;
      else if (refill_valid)
         fill_cnt <= fill_cnt + 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
      end else if (invalidate) begin
         valid_q <= '0;
      end else if (refill_done) begin
         valid_q[index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (refill_done)
         tag_mem[index] <= tag;
   end

   // refill words in order, else merge strobed bytes on a write hit
   always_ff @(posedge clk) begin
      if (refill_valid) begin
         data_mem[{index, fill_cnt}] <= refill_data;
      end else if (wtb_push && hit) begin
         for (int b = 0; b < nbytes; b++) begin
            if (wstrb[b])
               data_mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   // requested word is caught as it passes during a refill
   always_ff @(posedge clk) begin
      if (state == ST_LOOKUP && !is_write && hit)
         rdata_q <= data_mem[word_idx];
      else if (refill_valid && fill_cnt == offset)
         rdata_q <= refill_data;
   end

   credits_in_range: assert property (@(posedge clk) disable iff (!rst_n)
      credits <= max_credits);

   push_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
      wtb_push |-> credits != '0);

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

   // default geometry, overridden from cache_top
   // word address width
   localparam int def_addr_w = 12;
   localparam int def_data_w = 32;
   // log2 of the number of lines
   localparam int def_nlines_w = 3;
   // log2 of the words in one line
   localparam int def_word_offset_w = 2;
   // log2 of the write buffer depth
   localparam int def_wtbuf_depth_w = 2;

   // back-end sequencer
   // writes are drained first, a refill only starts from an empty buffer
   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      DRAIN  = 2'd1,
      REFILL = 2'd2
   } be_state_e;

endpackage

`default_nettype wire

// File: source/cache_top.sv
`default_nettype none

module cache_top #(
   parameter int ADDR_W        = cache_pkg::def_addr_w,
   parameter int DATA_W        = cache_pkg::def_data_w,
   parameter int NLINES_W      = cache_pkg::def_nlines_w,
   parameter int WORD_OFFSET_W = cache_pkg::def_word_offset_w,
   parameter int WTBUF_DEPTH_W = cache_pkg::def_wtbuf_depth_w
) (
   input  logic                clk,
   input  logic                rst_n,
   // front end
   input  logic                req,
   input  logic [ADDR_W-1:0]   addr,
   input  logic [DATA_W-1:0]   wdata,
   input  logic [DATA_W/8-1:0] wstrb,
   output logic [DATA_W-1:0]   rdata,
   output logic                ack,
   input  logic                invalidate,
   output logic                wtb_empty,
   // external memory
   output logic                mem_req,
   output logic                mem_we,
   output logic [ADDR_W-1:0]   mem_addr,
   output logic [DATA_W-1:0]   mem_wdata,
   output logic [DATA_W/8-1:0] mem_wstrb,
   input  logic [DATA_W-1:0]   mem_rdata,
   input  logic                mem_ack
);

   logic                            wtb_push;
   logic [ADDR_W-1:0]               wtb_push_addr;
   logic [DATA_W-1:0]               wtb_push_data;
   logic [DATA_W/8-1:0]             wtb_push_strb;
   logic                            credit_return;
   logic                            wtb_valid;
   logic [ADDR_W-1:0]               wtb_addr;
   logic [DATA_W-1:0]               wtb_data;
   logic [DATA_W/8-1:0]             wtb_strb;
   logic                            wtb_pop;
   logic                            refill_req;
   logic [ADDR_W-WORD_OFFSET_W-1:0] refill_addr;
   logic                            refill_valid;
   logic [DATA_W-1:0]               refill_data;
   logic                            refill_done;

   cache_memory #(
      .ADDR_W        (ADDR_W),
      .DATA_W        (DATA_W),
      .NLINES_W      (NLINES_W),
      .WORD_OFFSET_W (WORD_OFFSET_W),
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) memory (
      .clk           (clk),
      .rst_n         (rst_n),
      .req           (req),
      .addr          (addr),
      .wdata         (wdata),
      .wstrb         (wstrb),
      .rdata         (rdata),
      .ack           (ack),
      .invalidate    (invalidate),
      .wtb_push      (wtb_push),
      .wtb_push_addr (wtb_push_addr),
      .wtb_push_data (wtb_push_data),
      .wtb_push_strb (wtb_push_strb),
      .credit_return (credit_return),
      .refill_req    (refill_req),
      .refill_addr   (refill_addr),
      .refill_valid  (refill_valid),
      .refill_data   (refill_data),
      .refill_done   (refill_done)
   );

   write_through_buffer #(
      .ADDR_W        (ADDR_W),
      .DATA_W        (DATA_W),
      .WTBUF_DEPTH_W (WTBUF_DEPTH_W)
   ) wtbuf (
      .clk           (clk),
      .rst_n         (rst_n),
      .wtb_push      (wtb_push),
      .wtb_push_addr (wtb_push_addr),
      .wtb_push_data (wtb_push_data),
      .wtb_push_strb (wtb_push_strb),
      .credit_return (credit_return),
      .wtb_valid     (wtb_valid),
      .wtb_addr      (wtb_addr),
      .wtb_data      (wtb_data),
      .wtb_strb      (wtb_strb),
      .wtb_pop       (wtb_pop),
      .wtb_empty     (wtb_empty)
   );

   // sequencer runs IDLE, DRAIN and REFILL of be_state_e
   cache_back_end #(
      .ADDR_W        (ADDR_W),
      .DATA_W        (DATA_W),
      .WORD_OFFSET_W (WORD_OFFSET_W)
   ) back_end (
      .clk           (clk),
      .rst_n         (rst_n),
      .wtb_valid     (wtb_valid),
      .wtb_addr      (wtb_addr),
      .wtb_data      (wtb_data),
      .wtb_strb      (wtb_strb),
      .wtb_pop       (wtb_pop),
      .refill_req    (refill_req),
      .refill_addr   (refill_addr),
      .refill_valid  (refill_valid),
      .refill_data   (refill_data),
      .refill_done   (refill_done),
      .mem_req       (mem_req),
      .mem_we        (mem_we),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .mem_wstrb     (mem_wstrb),
      .mem_rdata     (mem_rdata),
      .mem_ack       (mem_ack)
   );

endmodule

`default_nettype wire

// File: source/write_through_buffer.sv
`default_nettype none

module write_through_buffer #(
   parameter int ADDR_W        = cache_pkg::def_addr_w,
   parameter int DATA_W        = cache_pkg::def_data_w,
   parameter int WTBUF_DEPTH_W = cache_pkg::def_wtbuf_depth_w
) (
   input  logic                clk,
   input  logic                rst_n,
   // from the cache memory
   input  logic                wtb_push,
   input  logic [ADDR_W-1:0]   wtb_push_addr,
   input  logic [DATA_W-1:0]   wtb_push_data,
   input  logic [DATA_W/8-1:0] wtb_push_strb,
   output logic                credit_return,
   // head entry towards the back end
   output logic                wtb_valid,
   output logic [ADDR_W-1:0]   wtb_addr,
   output logic [DATA_W-1:0]   wtb_data,
   output logic [DATA_W/8-1:0] wtb_strb,
   input  logic                wtb_pop,
   output logic                wtb_empty
);

   localparam int nbytes = DATA_W / 8;
   localparam int depth = 2**WTBUF_DEPTH_W;

   logic [ADDR_W-1:0] addr_mem [depth];
   logic [DATA_W-1:0] data_mem [depth];
   logic [nbytes-1:0] strb_mem [depth];

   // extra msb tells full from empty
   logic [WTBUF_DEPTH_W:0] wr_ptr;
   logic [WTBUF_DEPTH_W:0] rd_ptr;
   logic                   full;

   assign wtb_empty = (wr_ptr == rd_ptr);
   assign full = (wr_ptr == {~rd_ptr[WTBUF_DEPTH_W], rd_ptr[WTBUF_DEPTH_W-1:0]});
   assign wtb_valid = !wtb_empty;

   assign wtb_addr = addr_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];
   assign wtb_data = data_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];
   assign wtb_strb = strb_mem[rd_ptr[WTBUF_DEPTH_W-1:0]];

   always_ff @(posedge clk) begin
      if (wtb_push) begin
         addr_mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= wtb_push_addr;
         data_mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= wtb_push_data;
         strb_mem[wr_ptr[WTBUF_DEPTH_W-1:0]] <= wtb_push_strb;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         credit_return <= 1'b0;
      end else begin
         if (wtb_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (wtb_pop)
            rd_ptr <= rd_ptr + 1'b1;
         // one credit back per drained entry
         credit_return <= wtb_pop;
      end
   end

   no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
      wtb_push |-> !full);

   no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
      wtb_pop |-> !wtb_empty);

endmodule

`default_nettype wire

// File: verilog.f
source/cache_pkg.sv
source/cache_memory.sv
source/write_through_buffer.sv
source/cache_back_end.sv
source/cache_top.sv
dv/cache_checker.sv
dv/cache_tb.sv
